// File: verilog/vector_core_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shared types of the SIMD lane pipeline. Holds the two views of the
// instruction word, the ALU opcodes, the decoded operation and the
// writeback bookkeeping. Modules refer to them as vector_core_pkg::name
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package vector_core_pkg;

	localparam int WORD_WIDTH = 32;		// One lane, one scalar register
	localparam int REG_SEL_WIDTH = 5;	// 32 registers in each file
	localparam int IMM_WIDTH = 14;

	typedef enum logic [3:0] {
		ALU_ADD      = 4'd0,
		ALU_SUB      = 4'd1,
		ALU_AND      = 4'd2,
		ALU_OR       = 4'd3,
		ALU_XOR      = 4'd4,
		ALU_SHL      = 4'd5,	// Shift amount is low 5 bits of operand 2
		ALU_SHR      = 4'd6,	// Logical
		ALU_ADD_LANE = 4'd7		// Operand 1 plus lane index
	} alu_op_e;

	// Second operand comes from a register
	typedef struct packed {
		logic is_immediate;		// Format bit, low here
		alu_op_e alu_op;
		logic dest_is_vector;
		logic op1_is_vector;
		logic [REG_SEL_WIDTH-1:0] dest;
		logic [REG_SEL_WIDTH-1:0] src1;
		logic op2_is_vector;
		logic [REG_SEL_WIDTH-1:0] src2;
		logic [8:0] unused;
	} reg_fmt_t;

	// Second operand is a signed constant
	typedef struct packed {
		logic is_immediate;		// Format bit, high here
		alu_op_e alu_op;
		logic dest_is_vector;
		logic op1_is_vector;
		logic [REG_SEL_WIDTH-1:0] dest;
		logic [REG_SEL_WIDTH-1:0] src1;
		logic unused;
		logic signed [IMM_WIDTH-1:0] immediate;
	} imm_fmt_t;

	typedef union packed {
		reg_fmt_t reg_fmt;
		imm_fmt_t imm_fmt;
	} instruction_u;

	typedef struct packed {
		logic valid;
		alu_op_e alu_op;
		logic is_immediate;
		logic [WORD_WIDTH-1:0] immediate;	// Sign extended
		logic op1_is_vector;
		logic op2_is_vector;
		logic dest_is_vector;
		logic [REG_SEL_WIDTH-1:0] src1;
		logic [REG_SEL_WIDTH-1:0] src2;
		logic [REG_SEL_WIDTH-1:0] dest;
	} decoded_op_t;

	// Value travels beside this, its width follows the lane count
	typedef struct packed {
		logic valid;
		logic is_vector;
		logic [REG_SEL_WIDTH-1:0] dest;
	} writeback_meta_t;

endpackage

`default_nettype wire

// File: verilog/instruction_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~
// Decode stage. Splits the instruction word by its format bit, drives
// register selects to both files and registers the decoded operation
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module instruction_decoder (
	input  logic clk,
	input  logic rst_n_i,
	input  logic instr_valid_i,
	input  vector_core_pkg::instruction_u instr_i,
	output logic [vector_core_pkg::REG_SEL_WIDTH-1:0] scalar_sel1_o,
	output logic [vector_core_pkg::REG_SEL_WIDTH-1:0] scalar_sel2_o,
	output logic [vector_core_pkg::REG_SEL_WIDTH-1:0] vector_sel1_o,
	output logic [vector_core_pkg::REG_SEL_WIDTH-1:0] vector_sel2_o,
	output vector_core_pkg::decoded_op_t dec_op_o
);

	localparam int EXT_WIDTH = vector_core_pkg::WORD_WIDTH - vector_core_pkg::IMM_WIDTH;

	vector_core_pkg::decoded_op_t dec_op_next;

	always_comb
	begin
		dec_op_next = '0;
		dec_op_next.valid = instr_valid_i;
		// Shared fields sit at the same bits in both views
		dec_op_next.is_immediate = instr_i.reg_fmt.is_immediate;
		dec_op_next.alu_op = instr_i.reg_fmt.alu_op;
		dec_op_next.dest_is_vector = instr_i.reg_fmt.dest_is_vector;
		dec_op_next.op1_is_vector = instr_i.reg_fmt.op1_is_vector;
		dec_op_next.dest = instr_i.reg_fmt.dest;
		dec_op_next.src1 = instr_i.reg_fmt.src1;
		if (instr_i.imm_fmt.is_immediate)
		begin
			dec_op_next.immediate = {
				{EXT_WIDTH{instr_i.imm_fmt.immediate[vector_core_pkg::IMM_WIDTH-1]}},
				instr_i.imm_fmt.immediate
			};
		end
		else
		begin
			dec_op_next.op2_is_vector = instr_i.reg_fmt.op2_is_vector;
			dec_op_next.src2 = instr_i.reg_fmt.src2;
		end
	end

	// Same numbers go to both files, each reads its own register
	always_ff @(posedge clk)
	begin
		scalar_sel1_o <= dec_op_next.src1;
		scalar_sel2_o <= dec_op_next.src2;
		vector_sel1_o <= dec_op_next.src1;
		vector_sel2_o <= dec_op_next.src2;
		dec_op_o <= dec_op_next;
		if (!rst_n_i)
			dec_op_o.valid <= 1'b0;
	end

endmodule

`default_nettype wire

// File: verilog/scalar_register_file.sv
// ~~~~~~~~~~~~~~~~~~~~
// Scalar register file, 32 words. Two registered read ports, one write
// port fed by scalar writebacks. Reads see the value before a write
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module scalar_register_file (
	input  logic clk,
	input  logic rst_n_i,
	input  logic [vector_core_pkg::REG_SEL_WIDTH-1:0] sel1_i,
	input  logic [vector_core_pkg::REG_SEL_WIDTH-1:0] sel2_i,
	input  vector_core_pkg::writeback_meta_t wb_meta_i,
	input  logic [vector_core_pkg::WORD_WIDTH-1:0] wb_data_i,
	output logic [vector_core_pkg::WORD_WIDTH-1:0] value1_o,
	output logic [vector_core_pkg::WORD_WIDTH-1:0] value2_o
);

	localparam int NUM_REGS = 2 ** vector_core_pkg::REG_SEL_WIDTH;

	logic [vector_core_pkg::WORD_WIDTH-1:0] regs [NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wb_meta_i.valid && !wb_meta_i.is_vector)	// Scalar writes only
			regs[wb_meta_i.dest] <= wb_data_i;
	end

	always_ff @(posedge clk)
	begin
		value1_o <= regs[sel1_i];
		value2_o <= regs[sel2_i];
	end

endmodule

`default_nettype wire

// File: verilog/vector_register_file.sv
// ~~~~~~~~~~~~~~~~~~~~
// Vector register file, 32 registers of NUM_LANES words each.
// Two registered read ports and one whole-register write port
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module vector_register_file #(
	parameter int NUM_LANES = 16
) (
	input  logic clk,
	input  logic rst_n_i,
	input  logic [vector_core_pkg::REG_SEL_WIDTH-1:0] sel1_i,
	input  logic [vector_core_pkg::REG_SEL_WIDTH-1:0] sel2_i,
	input  vector_core_pkg::writeback_meta_t wb_meta_i,
	input  logic [NUM_LANES-1:0][vector_core_pkg::WORD_WIDTH-1:0] wb_value_i,
	output logic [NUM_LANES-1:0][vector_core_pkg::WORD_WIDTH-1:0] value1_o,
	output logic [NUM_LANES-1:0][vector_core_pkg::WORD_WIDTH-1:0] value2_o
);

	localparam int NUM_REGS = 2 ** vector_core_pkg::REG_SEL_WIDTH;

	logic [NUM_LANES-1:0][vector_core_pkg::WORD_WIDTH-1:0] regs [NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wb_meta_i.valid && wb_meta_i.is_vector)
		begin
			// No lane mask, every lane is written
			regs[wb_meta_i.dest] <= wb_value_i;
		end
	end

	always_ff @(posedge clk)
	begin
		value1_o <= regs[sel1_i];
		value2_o <= regs[sel2_i];
	end

endmodule

`default_nettype wire

// File: verilog/execute_unit.sv
// ~~~~~~~~~~~~~~~~~~~~
// Execute stage. Bypasses results the register files do not show yet,
// broadcasts scalars to every lane, runs the lane ALUs and holds the
// writeback register plus a one-cycle-delayed copy of it
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module execute_unit #(
	parameter int NUM_LANES = 16
) (
	input  logic clk,
	input  logic rst_n_i,
	input  vector_core_pkg::decoded_op_t dec_op_i,
	input  logic [vector_core_pkg::WORD_WIDTH-1:0] scalar1_i,
	input  logic [vector_core_pkg::WORD_WIDTH-1:0] scalar2_i,
	input  logic [NUM_LANES-1:0][vector_core_pkg::WORD_WIDTH-1:0] vector1_i,
	input  logic [NUM_LANES-1:0][vector_core_pkg::WORD_WIDTH-1:0] vector2_i,
	output vector_core_pkg::writeback_meta_t wb_meta_o,
	output logic [NUM_LANES-1:0][vector_core_pkg::WORD_WIDTH-1:0] wb_value_o
);

	localparam int W = vector_core_pkg::WORD_WIDTH;

	vector_core_pkg::decoded_op_t ex_op;		// Lines up with register file data
	vector_core_pkg::writeback_meta_t rf_meta;
	logic [NUM_LANES-1:0][W-1:0] rf_value;
	logic [W-1:0] scalar_op1;
	logic [W-1:0] scalar_op2;
	logic [NUM_LANES-1:0][W-1:0] vector_op1;
	logic [NUM_LANES-1:0][W-1:0] vector_op2;
	logic [NUM_LANES-1:0][W-1:0] lane_a;
	logic [NUM_LANES-1:0][W-1:0] lane_b;
	logic [NUM_LANES-1:0][W-1:0] result;

	// A source only matches a writeback of its own kind
	function automatic logic wb_hit(
		input vector_core_pkg::writeback_meta_t meta,
		input logic is_vector,
		input logic [vector_core_pkg::REG_SEL_WIDTH-1:0] sel
	);
		return meta.valid && (meta.is_vector == is_vector) && (meta.dest == sel);
	endfunction

	// Newest result first, then the delayed copy, then the file
	always_comb
	begin
		if (wb_hit(wb_meta_o, 1'b0, ex_op.src1))
			scalar_op1 = wb_value_o[0];
		else if (wb_hit(rf_meta, 1'b0, ex_op.src1))
			scalar_op1 = rf_value[0];
		else
			scalar_op1 = scalar1_i;

		if (wb_hit(wb_meta_o, 1'b0, ex_op.src2))
			scalar_op2 = wb_value_o[0];
		else if (wb_hit(rf_meta, 1'b0, ex_op.src2))
			scalar_op2 = rf_value[0];
		else
			scalar_op2 = scalar2_i;

		if (wb_hit(wb_meta_o, 1'b1, ex_op.src1))
			vector_op1 = wb_value_o;
		else if (wb_hit(rf_meta, 1'b1, ex_op.src1))
			vector_op1 = rf_value;
		else
			vector_op1 = vector1_i;

		if (wb_hit(wb_meta_o, 1'b1, ex_op.src2))
			vector_op2 = wb_value_o;
		else if (wb_hit(rf_meta, 1'b1, ex_op.src2))
			vector_op2 = rf_value;
		else
			vector_op2 = vector2_i;
	end

	// Scalar operands are broadcast
	always_comb
	begin
		for (int i = 0; i < NUM_LANES; i++)
		begin
			lane_a[i] = ex_op.op1_is_vector ? vector_op1[i] : scalar_op1;
			if (ex_op.is_immediate)
				lane_b[i] = ex_op.immediate;
			else if (ex_op.op2_is_vector)
				lane_b[i] = vector_op2[i];
			else
				lane_b[i] = scalar_op2;
		end
	end

	for (genvar lane = 0; lane < NUM_LANES; lane++)
	begin : g_lane
		always_comb
		begin
			case (ex_op.alu_op)
				vector_core_pkg::ALU_ADD: result[lane] = lane_a[lane] + lane_b[lane];
				vector_core_pkg::ALU_SUB: result[lane] = lane_a[lane] - lane_b[lane];
				vector_core_pkg::ALU_AND: result[lane] = lane_a[lane] & lane_b[lane];
				vector_core_pkg::ALU_OR:  result[lane] = lane_a[lane] | lane_b[lane];
				vector_core_pkg::ALU_XOR: result[lane] = lane_a[lane] ^ lane_b[lane];
				vector_core_pkg::ALU_SHL: result[lane] = lane_a[lane] << lane_b[lane][4:0];
				vector_core_pkg::ALU_SHR: result[lane] = lane_a[lane] >> lane_b[lane][4:0];
				vector_core_pkg::ALU_ADD_LANE: result[lane] = lane_a[lane] + W'(lane);
				default: result[lane] = '0;
			endcase
		end
	end

	// Delayed copy covers registers read just before their write lands
	always_ff @(posedge clk)
	begin
		ex_op <= dec_op_i;
		wb_meta_o.valid <= ex_op.valid;
		wb_meta_o.is_vector <= ex_op.dest_is_vector;
		wb_meta_o.dest <= ex_op.dest;
		wb_value_o <= result;	// Scalar destinations use lane 0
		rf_meta <= wb_meta_o;
		rf_value <= wb_value_o;
		if (!rst_n_i)
		begin
			ex_op.valid <= 1'b0;
			wb_meta_o.valid <= 1'b0;
			rf_meta.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/vector_core.sv
// ~~~~~~~~~~~~~~~~~~~~
// Top level of the SIMD lane pipeline. Takes one instruction per valid
// cycle and shows each result on the writeback port three cycles later.
// NUM_LANES sets the width of every vector register
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module vector_core #(
	parameter int NUM_LANES = 16
) (
	input  logic clk,
	input  logic rst_n_i,
	input  logic instr_valid_i,
	input  vector_core_pkg::instruction_u instr_i,
	output vector_core_pkg::writeback_meta_t wb_meta_o,
	output logic [NUM_LANES-1:0][vector_core_pkg::WORD_WIDTH-1:0] wb_value_o	// Lane 0 low
);

	logic [vector_core_pkg::REG_SEL_WIDTH-1:0] scalar_sel1;
	logic [vector_core_pkg::REG_SEL_WIDTH-1:0] scalar_sel2;
	logic [vector_core_pkg::REG_SEL_WIDTH-1:0] vector_sel1;
	logic [vector_core_pkg::REG_SEL_WIDTH-1:0] vector_sel2;
	vector_core_pkg::decoded_op_t dec_op;
	logic [vector_core_pkg::WORD_WIDTH-1:0] scalar_value1;
	logic [vector_core_pkg::WORD_WIDTH-1:0] scalar_value2;
	logic [NUM_LANES-1:0][vector_core_pkg::WORD_WIDTH-1:0] vector_value1;
	logic [NUM_LANES-1:0][vector_core_pkg::WORD_WIDTH-1:0] vector_value2;
	vector_core_pkg::writeback_meta_t wb_meta;
	logic [NUM_LANES-1:0][vector_core_pkg::WORD_WIDTH-1:0] wb_value;

	assign wb_meta_o = wb_meta;
	assign wb_value_o = wb_value;

	instruction_decoder i_decoder (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.scalar_sel1_o (scalar_sel1),
		.scalar_sel2_o (scalar_sel2),
		.vector_sel1_o (vector_sel1),
		.vector_sel2_o (vector_sel2),
		.dec_op_o      (dec_op)
	);

	// Scalar file keeps lane 0 of the result
	scalar_register_file i_scalar_rf (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.sel1_i    (scalar_sel1),
		.sel2_i    (scalar_sel2),
		.wb_meta_i (wb_meta),
		.wb_data_i (wb_value[0]),
		.value1_o  (scalar_value1),
		.value2_o  (scalar_value2)
	);

	vector_register_file #(
		.NUM_LANES (NUM_LANES)
	) i_vector_rf (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.sel1_i     (vector_sel1),
		.sel2_i     (vector_sel2),
		.wb_meta_i  (wb_meta),
		.wb_value_i (wb_value),
		.value1_o   (vector_value1),
		.value2_o   (vector_value2)
	);

	execute_unit #(
		.NUM_LANES (NUM_LANES)
	) i_execute (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.dec_op_i   (dec_op),
		.scalar1_i  (scalar_value1),
		.scalar2_i  (scalar_value2),
		.vector1_i  (vector_value1),
		.vector2_i  (vector_value2),
		.wb_meta_o  (wb_meta),
		.wb_value_o (wb_value)
	);

endmodule

`default_nettype wire

// File: include/vector_core_tb_cases.svh
// ~~~~~~~~~~~~~~~~~~~~
// Stimulus table for the pipeline testbench, applied one entry per cycle.
// Instructions build on each other, so the order matters
// ~~~~~~~~~~~~~~~~~~~~

`ifndef VECTOR_CORE_TB_CASES_SVH
`define VECTOR_CORE_TB_CASES_SVH

// Columns: instruction (op, dest kind, dest, src1 kind, src1, imm or src2 kind and src2),
// then expected dest and lanes. s<n> is a scalar register, v<n> a vector register
task automatic load_cases();
	expect_scalar(make_imm_instr(vector_core_pkg::ALU_ADD, 1'b0, 5'd1, 1'b0, 5'd0, 100),
		5'd1, 32'h0000_0064);	// s1 = 100
	expect_scalar(make_imm_instr(vector_core_pkg::ALU_ADD, 1'b0, 5'd2, 1'b0, 5'd0, -5),
		5'd2, 32'hffff_fffb);	// s2 = -5
	expect_scalar(make_imm_instr(vector_core_pkg::ALU_ADD, 1'b0, 5'd3, 1'b0, 5'd0, 'h1234),
		5'd3, 32'h0000_1234);
	// s4 = s1 - s2, s1 three slots back, s2 two slots back
	expect_scalar(make_reg_instr(vector_core_pkg::ALU_SUB, 1'b0, 5'd4, 1'b0, 5'd1, 1'b0, 5'd2),
		5'd4, 32'h0000_0069);
	expect_scalar(make_reg_instr(vector_core_pkg::ALU_AND, 1'b0, 5'd5, 1'b0, 5'd3, 1'b0, 5'd4),
		5'd5, 32'h0000_0020);	// s4 from the previous slot
	expect_scalar(make_reg_instr(vector_core_pkg::ALU_OR, 1'b0, 5'd6, 1'b0, 5'd1, 1'b0, 5'd3),
		5'd6, 32'h0000_1274);
	expect_scalar(make_reg_instr(vector_core_pkg::ALU_XOR, 1'b0, 5'd7, 1'b0, 5'd6, 1'b0, 5'd2),
		5'd7, 32'hffff_ed8f);
	expect_scalar(make_imm_instr(vector_core_pkg::ALU_SHL, 1'b0, 5'd8, 1'b0, 5'd1, 4),
		5'd8, 32'h0000_0640);
	expect_scalar(make_imm_instr(vector_core_pkg::ALU_SHR, 1'b0, 5'd9, 1'b0, 5'd2, 28),
		5'd9, 32'h0000_000f);	// Logical, no sign fill
	// v1 = s1 broadcast plus lane index
	expect_vector(make_imm_instr(vector_core_pkg::ALU_ADD_LANE, 1'b1, 5'd1, 1'b0, 5'd1, 0),
		5'd1, 32'h64, 32'h65, 32'h66, 32'h67);
	expect_vector(make_imm_instr(vector_core_pkg::ALU_ADD_LANE, 1'b1, 5'd2, 1'b1, 5'd1, 0),
		5'd2, 32'h64, 32'h66, 32'h68, 32'h6a);
	expect_vector(make_reg_instr(vector_core_pkg::ALU_SUB, 1'b1, 5'd3, 1'b1, 5'd2, 1'b0, 5'd1),
		5'd3, 32'h0, 32'h2, 32'h4, 32'h6);
	// Mixed operands into a scalar destination, lane 0 only
	expect_scalar(make_reg_instr(vector_core_pkg::ALU_ADD, 1'b0, 5'd11, 1'b1, 5'd3, 1'b0, 5'd9),
		5'd11, 32'h0000_000f);
	expect_vector(make_imm_instr(vector_core_pkg::ALU_ADD_LANE, 1'b1, 5'd5, 1'b0, 5'd7, 0),
		5'd5, 32'hffff_ed8f, 32'hffff_ed90, 32'hffff_ed91, 32'hffff_ed92);
	// Vector 5 in flight must not shadow scalar 5
	expect_vector(make_reg_instr(vector_core_pkg::ALU_ADD, 1'b1, 5'd6, 1'b1, 5'd5, 1'b0, 5'd5),
		5'd6, 32'hffff_edaf, 32'hffff_edb0, 32'hffff_edb1, 32'hffff_edb2);
	expect_scalar(make_reg_instr(vector_core_pkg::ALU_XOR, 1'b0, 5'd12, 1'b0, 5'd5, 1'b0, 5'd11),
		5'd12, 32'h0000_002f);
	// v4 was never written, only s4
	expect_vector(make_reg_instr(vector_core_pkg::ALU_OR, 1'b1, 5'd7, 1'b1, 5'd4, 1'b1, 5'd2),
		5'd7, 32'h64, 32'h66, 32'h68, 32'h6a);
	// s5 and s6 from the file after v5 and v6 have landed there
	expect_scalar(make_reg_instr(vector_core_pkg::ALU_ADD, 1'b0, 5'd13, 1'b0, 5'd5, 1'b0, 5'd6),
		5'd13, 32'h0000_1294);
endtask

`endif

// File: test/vector_core_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the SIMD lane pipeline with 4 lanes. Applies the
// included table back to back and checks every writeback and its timing
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module vector_core_tb;

	localparam int NUM_LANES = 4;
	localparam realtime CLK_PERIOD = 10.0;
	localparam int RESET_CYCLES = 10;
	localparam int LATENCY = 3;	// Cycles from the driving edge to the writeback

	typedef struct packed {
		vector_core_pkg::instruction_u instr;
		logic is_vector;
		logic [vector_core_pkg::REG_SEL_WIDTH-1:0] dest;
		logic [NUM_LANES-1:0][vector_core_pkg::WORD_WIDTH-1:0] lanes;
	} case_t;

	typedef struct packed {
		logic [31:0] index;
		logic [31:0] due;
	} pending_t;

	logic clk;
	logic rst_n_i;
	logic instr_valid_i;
	vector_core_pkg::instruction_u instr_i;
	vector_core_pkg::writeback_meta_t wb_meta;
	logic [NUM_LANES-1:0][vector_core_pkg::WORD_WIDTH-1:0] wb_value;

	case_t cases[$];
	pending_t pending[$];	// Issued, result not seen yet
	logic [31:0] cycle;
	bit table_loaded = 1'b0;

	vector_core #(
		.NUM_LANES (NUM_LANES)
	) i_dut (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.wb_meta_o     (wb_meta),
		.wb_value_o    (wb_value)
	);

	function automatic vector_core_pkg::instruction_u make_imm_instr(
		input vector_core_pkg::alu_op_e op,
		input logic dest_vec,
		input logic [4:0] dest,
		input logic src1_vec,
		input logic [4:0] src1,
		input int imm
	);
		vector_core_pkg::instruction_u u;
		u = '0;
		u.imm_fmt.is_immediate = 1'b1;
		u.imm_fmt.alu_op = op;
		u.imm_fmt.dest_is_vector = dest_vec;
		u.imm_fmt.op1_is_vector = src1_vec;
		u.imm_fmt.dest = dest;
		u.imm_fmt.src1 = src1;
		u.imm_fmt.immediate = imm[13:0];	// Low 14 bits, two's complement
		return u;
	endfunction

	function automatic vector_core_pkg::instruction_u make_reg_instr(
		input vector_core_pkg::alu_op_e op,
		input logic dest_vec,
		input logic [4:0] dest,
		input logic src1_vec,
		input logic [4:0] src1,
		input logic src2_vec,
		input logic [4:0] src2
	);
		vector_core_pkg::instruction_u u;
		u = '0;
		u.reg_fmt.alu_op = op;
		u.reg_fmt.dest_is_vector = dest_vec;
		u.reg_fmt.op1_is_vector = src1_vec;
		u.reg_fmt.dest = dest;
		u.reg_fmt.src1 = src1;
		u.reg_fmt.op2_is_vector = src2_vec;
		u.reg_fmt.src2 = src2;
		return u;
	endfunction

	task automatic expect_scalar(input vector_core_pkg::instruction_u instr,
		input logic [4:0] dest, input logic [31:0] value);
		cases.push_back('{instr: instr, is_vector: 1'b0, dest: dest, lanes: {96'h0, value}});
	endtask

	task automatic expect_vector(input vector_core_pkg::instruction_u instr,
		input logic [4:0] dest, input logic [31:0] l0, input logic [31:0] l1,
		input logic [31:0] l2, input logic [31:0] l3);
		cases.push_back('{instr: instr, is_vector: 1'b1, dest: dest, lanes: {l3, l2, l1, l0}});
	endtask

	`include "vector_core_tb_cases.svh"

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
			stop_with_failure($sformatf("error @ %0t: %s: got %h, expected %h",
				$time, what, actual, expected));
	endtask

	task automatic check_writeback(input pending_t p);
		case_t c;
		c = cases[p.index];
		check_equal(cycle, p.due, $sformatf("case %0d writeback cycle", p.index));
		check_equal(wb_meta.is_vector, c.is_vector, $sformatf("case %0d is_vector", p.index));
		check_equal(wb_meta.dest, c.dest, $sformatf("case %0d dest", p.index));
		if (c.is_vector)
		begin
			for (int lane = 0; lane < NUM_LANES; lane++)
				check_equal(wb_value[lane], c.lanes[lane],
					$sformatf("case %0d lane %0d", p.index, lane));
		end
		else
			check_equal(wb_value[0], c.lanes[0], $sformatf("case %0d lane 0", p.index));
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	// Outputs settle after the rising edge, so look at the falling one
	always @(negedge clk)
	begin
		if (wb_meta.valid === 1'b1)
		begin
			if (pending.size() == 0)
				stop_with_failure("A writeback arrived when no result was expected");
			else
				check_writeback(pending.pop_front());
		end
		else if (pending.size() != 0 && cycle >= pending[0].due)
			stop_with_failure($sformatf(
				"The writeback of case %0d is missing %0d cycles after its instruction",
				pending[0].index, LATENCY));
	end

	initial
	begin
		wait (table_loaded);
		#((cases.size() + 20) * CLK_PERIOD);
		stop_with_failure("Timeout: the pipeline did not finish the table in time");
	end

	initial
	begin
		cycle = '0;
		rst_n_i = 1'b0;
		instr_valid_i = 1'b0;
		instr_i = '0;
		load_cases();
		table_loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n_i <= 1'b1;
		foreach (cases[i])
		begin
			@(posedge clk);
			instr_valid_i <= 1'b1;
			instr_i <= cases[i].instr;
			pending.push_back('{index: i, due: cycle + 1 + LATENCY});
		end
		@(posedge clk);
		instr_valid_i <= 1'b0;
		instr_i <= '0;
		while (pending.size() != 0)
			@(negedge clk);
		repeat (3) @(negedge clk);	// Nothing more may come out
		@(posedge clk);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
verilog/vector_core_pkg.sv
verilog/instruction_decoder.sv
verilog/scalar_register_file.sv
verilog/vector_register_file.sv
verilog/execute_unit.sv
verilog/vector_core.sv
test/vector_core_tb.sv

// File: Bender.yml
package:
  name: vector_core

sources:
  - files:
      - verilog/vector_core_pkg.sv
      - verilog/instruction_decoder.sv
      - verilog/scalar_register_file.sv
      - verilog/vector_register_file.sv
      - verilog/execute_unit.sv
      - verilog/vector_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/vector_core_tb.sv
